// ==== tb/icache_cases.txt ====
# op arg hit name  (READ arg is a byte address, hit is 1 if it must hit on its first cycle)
# CSRRD and CSRWR arg is a register, 1 hits 2 misses; INVAL arg is the CTRL write data
READ  00000040 0 cold_miss_w0
READ  00000044 1 line_hit_w1
READ  00000048 1 line_hit_w2
READ  0000004c 1 line_hit_w3
READ  00000140 0 conflict_miss
READ  00000040 0 conflict_readback
READ  00000044 1 readback_hit
CSRRD 1        0 hit_count_first
CSRRD 2        0 miss_count_first
INVAL 1        0 invalidate_all
READ  00000048 0 after_inval_miss
CSRWR 1        0 clear_hits
CSRRD 1        0 hit_count_cleared
CSRWR 2        0 clear_misses
CSRRD 2        0 miss_count_cleared
READ  00001238 0 burst_a_miss
READ  00002a74 0 burst_b_miss
READ  00003ff0 0 burst_c_miss
READ  00001230 1 burst_a_hit
READ  0000abcc 0 burst_d_miss
READ  00002a70 1 burst_b_hit
CSRRD 1        0 hit_count_burst
CSRRD 2        0 miss_count_burst

// ==== icache_top.f ====
source/icache_geometry_pkg.sv
source/icache_bus_pkg.sv
source/icache_line_store.sv
source/icache_fill_buffer.sv
source/icache_controller.sv
source/icache_csr.sv
source/icache_top.sv
tb/icache_assertions.sv
tb/icache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=icache_sim

verilator --binary --timing --assert \
    -f icache_top.f \
    --top-module icache_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$("./$BUILD_DIR/$SIM_BIN")
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

    import icache_geometry_pkg::*;
    import icache_bus_pkg::*;

    localparam int          READ_TIMEOUT = 200;     // Cycles, covers slow refills
    localparam int          BUSY_TIMEOUT = 20;
    localparam logic [31:0] SEED         = 32'h64ac6ff3;

    logic       clock = 1'b0;
    logic       reset;
    inst_addr_t addr;
    logic       rd;
    inst_t      inst;
    logic       hit;
    logic       busy;
    mem_req_t   mem_req;
    logic       mem_credit = 1'b0;
    mem_rsp_t   mem_rsp    = '0;
    csr_req_t   csr_req;
    logic [15:0] csr_rdata;

    mem_req_t    req_seen = '0;     // Request sampled mid-cycle
    word_addr_t  pend_addr [$];     // Memory slots, in request order
    int unsigned pend_due  [$];
    int unsigned cycle_count;
    int          hit_total;         // Expected counter values
    int          miss_total;

    int                 fd;
    int                 code;
    logic [8*8-1:0]     op_v;
    logic [31:0]        arg_v;
    int                 flag_v;
    logic [8*32-1:0]    name_v;
    logic [8*160-1:0]   rest_v;
    string              test_name;

    icache_top dut_i (
        .i_clock      (clock),
        .i_reset      (reset),
        .i_addr       (addr),
        .i_rd         (rd),
        .o_inst       (inst),
        .o_hit        (hit),
        .o_busy       (busy),
        .o_mem_req    (mem_req),
        .i_mem_credit (mem_credit),
        .i_mem_rsp    (mem_rsp),
        .i_csr        (csr_req),
        .o_csr_rdata  (csr_rdata)
    );

    always #50 clock = ~clock;      // 100 ns period

    // ------------------------------------------------------------------------
    // Memory model
    // ------------------------------------------------------------------------

    // Upper 30 bits W xor constant, low bits W[1:0]
    function automatic inst_t mem_word(input word_addr_t w);
        logic [31:0] mixed;
        mixed = {2'b00, w} ^ 32'h1234_5678;
        return {mixed[29:0], w[1:0]};
    endfunction

    always @(negedge clock) req_seen = mem_req;

    always @(posedge clock) begin
        if (reset) begin
            cycle_count = 0;
            pend_addr.delete();
            pend_due.delete();
            mem_rsp    <= '0;
            mem_credit <= 1'b0;
        end else begin
            if (req_seen.valid) begin
                if (pend_addr.size() >= MEM_CREDITS) begin
                    $display("Memory got a request while all its slots were in use");
                    stop_on_failure();
                end
                pend_addr.push_back(req_seen.addr);
                pend_due.push_back(cycle_count + 1 + ($urandom % 4));  // 1 to 4 cycles
            end
            cycle_count++;
            // In order, one answer per cycle, credit back with it
            if ((pend_due.size() != 0) && (pend_due[0] <= cycle_count)) begin
                mem_rsp    <= '{valid: 1'b1, data: mem_word(pend_addr.pop_front())};
                mem_credit <= 1'b1;
                void'(pend_due.pop_front());
            end else begin
                mem_rsp    <= '0;
                mem_credit <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Checks and case operations
    // ------------------------------------------------------------------------

    task automatic stop_on_failure();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic wait_busy(input logic level, input string name);
        int waited;
        waited = 0;
        @(negedge clock);
        while (busy !== level) begin
            if (waited >= BUSY_TIMEOUT) begin
                $display("Busy never went to %0d during %s", level, name);
                stop_on_failure();
            end
            @(negedge clock);
            waited++;
        end
    endtask

    task automatic run_read(input logic [31:0] byte_addr, input int hit_flag,
                            input string name);
        int    waited;
        logic  first_hit;
        logic  saw_busy;
        inst_t got;
        @(posedge clock);
        rd      <= 1'b1;
        addr    <= byte_addr;       // Held until hit
        csr_req <= '0;
        @(negedge clock);
        first_hit = hit;
        saw_busy  = 1'b0;
        waited    = 0;
        while (hit !== 1'b1) begin
            if (waited >= READ_TIMEOUT) begin
                $display("Cache never answered the read in %s", name);
                stop_on_failure();
            end
            @(negedge clock);
            saw_busy = saw_busy | busy;
            waited++;
        end
        got = inst;
        check_value({name, " first-cycle hit"}, hit_flag, 32'(first_hit));
        if (hit_flag == 0) begin
            check_value({name, " busy"}, 32'd1, 32'(saw_busy));
        end
        check_value({name, " inst"}, mem_word(byte_addr[31:2]), got);
        if (hit_flag != 0) hit_total++;
        else miss_total++;
    endtask

    task automatic csr_write(input logic [1:0] reg_addr, input logic [15:0] data);
        @(posedge clock);
        rd      <= 1'b0;
        csr_req <= '{write: 1'b1, addr: reg_addr, wdata: data};
    endtask

    task automatic run_invalidate(input logic [15:0] data, input string name);
        csr_write(2'(CTRL), data);
        @(posedge clock);
        csr_req <= '0;              // Strobe for one cycle
        wait_busy(1'b1, name);      // CLEAR
        wait_busy(1'b0, name);
    endtask

    task automatic csr_read_check(input logic [1:0] reg_addr, input string name);
        logic [31:0] expected;
        @(posedge clock);
        rd      <= 1'b0;
        csr_req <= '{write: 1'b0, addr: reg_addr, wdata: 16'h0000};
        @(negedge clock);
        case (reg_addr)
            2'(HIT_COUNT):  expected = 32'(hit_total);
            2'(MISS_COUNT): expected = 32'(miss_total);
            default:        expected = 32'd0;
        endcase
        check_value(name, expected, 32'(csr_rdata));
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        reset      = 1'b1;
        rd         = 1'b0;
        addr       = '0;
        csr_req    = '0;
        hit_total  = 0;
        miss_total = 0;
        void'($urandom(SEED));
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        fd = $fopen("tb/icache_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file tb/icache_cases.txt");
            stop_on_failure();
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", op_v);
            if (code != 1) break;
            if (op_v == "#") begin
                void'($fgets(rest_v, fd));      // Comment line
                continue;
            end
            code = $fscanf(fd, " %h %d %s", arg_v, flag_v, name_v);
            if (code != 3) begin
                $display("Malformed line in the cases file");
                stop_on_failure();
            end
            test_name = $sformatf("%0s", name_v);
            if (op_v == "READ") run_read(arg_v, flag_v, test_name);
            else if (op_v == "INVAL") run_invalidate(arg_v[15:0], test_name);
            else if (op_v == "CSRRD") csr_read_check(arg_v[1:0], test_name);
            else if (op_v == "CSRWR") begin
                csr_write(arg_v[1:0], 16'h0000);
                if (arg_v[1:0] == 2'(HIT_COUNT)) hit_total = 0;
                if (arg_v[1:0] == 2'(MISS_COUNT)) miss_total = 0;
            end else begin
                $display("Unknown operation in the cases file");
                stop_on_failure();
            end
        end
        $fclose(fd);
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== tb/icache_assertions.sv ====
`timescale 1ns/1ps

module icache_assertions (
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  icache_bus_pkg::mem_req_t       i_mem_req,
    input  logic                           i_mem_credit,    // Slot freed by memory
    input  icache_geometry_pkg::credit_t   i_credit,        // Controller credit counter
    input  logic                           i_hit,
    input  logic                           i_busy
);

    import icache_geometry_pkg::*;

    credit_t bus_credit_q;      // Credits as seen on the memory bus

    // ------------------------------------------------------------------------
    // Memory side credits
    // ------------------------------------------------------------------------

    // Spent by each request, returned by each credit pulse
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            bus_credit_q <= credit_t'(MEM_CREDITS);
        end else begin
            bus_credit_q <= bus_credit_q - credit_t'(i_mem_req.valid) +
                            credit_t'(i_mem_credit);
        end
    end

    assert property (@(posedge i_clock) disable iff (i_reset)
                     i_mem_req.valid |-> (bus_credit_q != '0))
        else $error("Memory request raised with zero credits");

    assert property (@(posedge i_clock) disable iff (i_reset)
                     i_credit <= credit_t'(MEM_CREDITS))
        else $error("Credit counter above memory depth");

    // ------------------------------------------------------------------------
    // Fetch side
    // ------------------------------------------------------------------------

    assert property (@(posedge i_clock) disable iff (i_reset)
                     !(i_hit && i_busy))
        else $error("Hit and busy high together");

    // First cycle out of reset
    assert property (@(posedge i_clock) $fell(i_reset) |-> !i_busy)
        else $error("Busy high right after reset");

endmodule

bind icache_top icache_assertions assertions_i (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_mem_req    (o_mem_req),
    .i_mem_credit (i_mem_credit),
    .i_credit     (controller_i.credit_q),
    .i_hit        (o_hit),
    .i_busy       (o_busy)
);

// ==== source/icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
    input  logic                             i_clock,
    input  logic                             i_reset,

    input  icache_geometry_pkg::inst_addr_t  i_addr,    // Held until o_hit
    input  logic                             i_rd,
    output icache_geometry_pkg::inst_t       o_inst,
    output logic                             o_hit,
    output logic                             o_busy,

    output icache_bus_pkg::mem_req_t         o_mem_req,
    input  logic                             i_mem_credit,
    input  icache_bus_pkg::mem_rsp_t         i_mem_rsp,

    input  icache_bus_pkg::csr_req_t         i_csr,
    output logic [15:0]                      o_csr_rdata
);

    import icache_geometry_pkg::*;

    word_addr_t word_addr;
    tag_t       tag;
    index_t     index;
    offset_t    offset;

    logic       lookup_hit;
    line_t      lookup_line;
    line_t      fill_line;
    offset_t    fill_slot;
    logic       line_write;
    logic       line_clear;
    logic       invalidate;
    logic       hit_event;
    logic       miss_event;

    // ------------------------------------------------------------------------
    // Address split and word select
    // ------------------------------------------------------------------------

    assign word_addr = i_addr[31:2];                    // Byte bits dropped
    assign {tag, index, offset} = word_addr;
    assign o_inst = lookup_line[offset*INST_WIDTH +: INST_WIDTH];

    // ------------------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------------------

    icache_controller controller_i (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_rd            (i_rd),
        .i_tag           (tag),
        .i_index         (index),
        .i_lookup_hit    (lookup_hit),
        .i_invalidate    (invalidate),
        .i_mem_credit    (i_mem_credit),
        .i_mem_rsp_valid (i_mem_rsp.valid),
        .o_mem_req       (o_mem_req),
        .o_slot          (fill_slot),
        .o_write         (line_write),
        .o_clear         (line_clear),
        .o_busy          (o_busy),
        .o_hit           (o_hit),
        .o_hit_event     (hit_event),
        .o_miss_event    (miss_event)
    );

    // Write uses the live address, stable while the fetch waits
    icache_line_store line_store_i (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_lookup_index (index),
        .i_lookup_tag   (tag),
        .o_lookup_hit   (lookup_hit),
        .o_lookup_line  (lookup_line),
        .i_write        (line_write),
        .i_write_index  (index),
        .i_write_tag    (tag),
        .i_write_line   (fill_line),
        .i_clear        (line_clear)
    );

    icache_fill_buffer fill_buffer_i (
        .i_clock (i_clock),
        .i_rsp   (i_mem_rsp),
        .i_slot  (fill_slot),
        .o_line  (fill_line)
    );

    icache_csr csr_i (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_csr        (i_csr),
        .o_csr_rdata  (o_csr_rdata),
        .i_hit_event  (hit_event),
        .i_miss_event (miss_event),
        .o_invalidate (invalidate)
    );

endmodule

// ==== source/icache_csr.sv ====
`timescale 1ns/1ps

module icache_csr (
    input  logic                        i_clock,
    input  logic                        i_reset,

    input  icache_bus_pkg::csr_req_t    i_csr,
    output logic [15:0]                 o_csr_rdata,

    input  logic                        i_hit_event,
    input  logic                        i_miss_event,
    output logic                        o_invalidate   // One-cycle pulse
);

    import icache_geometry_pkg::*;
    import icache_bus_pkg::*;

    count_t hit_count_q;
    count_t miss_count_q;
    logic   invalidate_q;

    // ------------------------------------------------------------------------
    // Command and counters
    // ------------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            hit_count_q  <= '0;
            miss_count_q <= '0;
            invalidate_q <= 1'b0;
        end else begin
            invalidate_q <= i_csr.write && (i_csr.addr == CTRL) && i_csr.wdata[0];

            if (i_csr.write && (i_csr.addr == HIT_COUNT)) begin
                hit_count_q <= '0;                  // Clear on write
            end else if (i_hit_event && (hit_count_q != '1)) begin
                hit_count_q <= hit_count_q + 1'b1;  // Saturates
            end

            if (i_csr.write && (i_csr.addr == MISS_COUNT)) begin
                miss_count_q <= '0;
            end else if (i_miss_event && (miss_count_q != '1)) begin
                miss_count_q <= miss_count_q + 1'b1;
            end
        end
    end

    assign o_invalidate = invalidate_q;

    // ------------------------------------------------------------------------
    // Read mux, combinational
    // ------------------------------------------------------------------------

    always_comb begin
        case (i_csr.addr)
            HIT_COUNT:  o_csr_rdata = hit_count_q;
            MISS_COUNT: o_csr_rdata = miss_count_q;
            default:    o_csr_rdata = '0;           // CTRL and unmapped
        endcase
    end

endmodule

// ==== source/icache_controller.sv ====
`timescale 1ns/1ps

module icache_controller (
    input  logic                          i_clock,
    input  logic                          i_reset,

    input  logic                          i_rd,            // Fetch read strobe
    input  icache_geometry_pkg::tag_t     i_tag,
    input  icache_geometry_pkg::index_t   i_index,
    input  logic                          i_lookup_hit,
    input  logic                          i_invalidate,    // One-cycle request

    input  logic                          i_mem_credit,    // Slot freed
    input  logic                          i_mem_rsp_valid,
    output icache_bus_pkg::mem_req_t      o_mem_req,

    output icache_geometry_pkg::offset_t  o_slot,          // Fill buffer slot
    output logic                          o_write,         // Line store write
    output logic                          o_clear,         // Drop all valid bits
    output logic                          o_busy,
    output logic                          o_hit,
    output logic                          o_hit_event,
    output logic                          o_miss_event
);

    import icache_geometry_pkg::*;
    import icache_bus_pkg::*;

    ctrl_state_e           state_q;
    ctrl_state_e           state_d;
    tag_t                  miss_tag_q;         // Line being refilled
    index_t                miss_index_q;
    credit_t               credit_q;
    logic [OFFSET_WIDTH:0] req_count_q;        // Counts up to LINE_WORDS
    offset_t               rsp_count_q;        // Wraps after last word
    logic                  inval_pending_q;
    logic                  retry_q;            // First IDLE cycle after WRITE

    logic                  inval_req;
    logic                  miss;
    logic                  req_fire;
    logic                  last_rsp;

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------

    assign inval_req = inval_pending_q || i_invalidate;
    // Invalidate wins over a miss in the same cycle
    assign miss      = (state_q == IDLE) && i_rd && !i_lookup_hit && !inval_req;
    assign req_fire  = (state_q == REFILL) && (credit_q != '0) &&
                       (req_count_q < (OFFSET_WIDTH + 1)'(LINE_WORDS));
    assign last_rsp  = (state_q == REFILL) && i_mem_rsp_valid &&
                       (rsp_count_q == offset_t'(LINE_WORDS - 1));

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (inval_req) begin
                    state_d = CLEAR;
                end else if (miss) begin
                    state_d = REFILL;
                end
            end
            REFILL:  state_d = last_rsp ? WRITE : REFILL;
            WRITE:   state_d = IDLE;          // One write cycle
            CLEAR:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state_q         <= IDLE;
            credit_q        <= credit_t'(MEM_CREDITS);   // Memory starts empty
            req_count_q     <= '0;
            rsp_count_q     <= '0;
            inval_pending_q <= 1'b0;
            retry_q         <= 1'b0;
        end else begin
            state_q  <= state_d;
            retry_q  <= (state_q == WRITE);
            // Spend on request, refund on credit pulse
            credit_q <= credit_q - credit_t'(req_fire) + credit_t'(i_mem_credit);

            if (miss) begin
                req_count_q <= '0;
                rsp_count_q <= '0;
            end else begin
                if (req_fire) begin
                    req_count_q <= req_count_q + 1'b1;
                end
                if ((state_q == REFILL) && i_mem_rsp_valid) begin
                    rsp_count_q <= rsp_count_q + 1'b1;
                end
            end

            // Held across a refill, taken in IDLE
            if ((state_q == IDLE) && inval_req) begin
                inval_pending_q <= 1'b0;
            end else if (i_invalidate) begin
                inval_pending_q <= 1'b1;
            end
        end
    end

    // Missing line address, payload only
    always_ff @(posedge i_clock) begin
        if (miss) begin
            miss_tag_q   <= i_tag;
            miss_index_q <= i_index;
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------

    assign o_mem_req    = '{valid: req_fire,
                            addr:  {miss_tag_q, miss_index_q,
                                    req_count_q[OFFSET_WIDTH-1:0]}};
    assign o_slot       = rsp_count_q;
    assign o_write      = (state_q == WRITE);
    assign o_clear      = (state_q == CLEAR);
    assign o_busy       = (state_q != IDLE);            // REFILL, WRITE, CLEAR
    assign o_hit        = (state_q == IDLE) && i_rd && i_lookup_hit;
    assign o_hit_event  = o_hit && !retry_q;            // Refill completion not a hit
    assign o_miss_event = miss;

endmodule

// ==== source/icache_fill_buffer.sv ====
`timescale 1ns/1ps

module icache_fill_buffer (
    input  logic                          i_clock,
    input  icache_bus_pkg::mem_rsp_t      i_rsp,    // Memory answer
    input  icache_geometry_pkg::offset_t  i_slot,   // Word of the line
    output icache_geometry_pkg::line_t    o_line
);

    import icache_geometry_pkg::*;

    inst_t words_q [LINE_WORDS];    // Line under refill

    // ------------------------------------------------------------------------
    // Word capture
    // ------------------------------------------------------------------------

    // Slot comes from the response count, not the request count,
    // so two words in flight still land in order
    always_ff @(posedge i_clock) begin
        if (i_rsp.valid) begin
            words_q[i_slot] <= i_rsp.data;
        end
    end

    // ------------------------------------------------------------------------
    // Line assembly
    // ------------------------------------------------------------------------

    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            o_line[w*INST_WIDTH +: INST_WIDTH] = words_q[w];   // Word 0 low
        end
    end

endmodule

// ==== source/icache_line_store.sv ====
`timescale 1ns/1ps

module icache_line_store (
    input  logic                          i_clock,
    input  logic                          i_reset,

    input  icache_geometry_pkg::index_t   i_lookup_index,
    input  icache_geometry_pkg::tag_t     i_lookup_tag,
    output logic                          o_lookup_hit,
    output icache_geometry_pkg::line_t    o_lookup_line,

    input  logic                          i_write,
    input  icache_geometry_pkg::index_t   i_write_index,
    input  icache_geometry_pkg::tag_t     i_write_tag,
    input  icache_geometry_pkg::line_t    i_write_line,

    input  logic                          i_clear
);

    import icache_geometry_pkg::*;

    logic [LINES-1:0] valid_q;              // One bit per entry
    tag_t             tag_mem  [LINES];
    line_t            line_mem [LINES];

    // ------------------------------------------------------------------------
    // Valid bits
    // ------------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset || i_clear) begin
            valid_q <= '0;                  // Invalidate all
        end else if (i_write) begin
            valid_q[i_write_index] <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Tag and data arrays
    // ------------------------------------------------------------------------

    // Whole line plus tag in one cycle
    always_ff @(posedge i_clock) begin
        if (i_write) begin
            tag_mem[i_write_index]  <= i_write_tag;
            line_mem[i_write_index] <= i_write_line;
        end
    end

    // Lookup is purely combinational
    assign o_lookup_hit  = valid_q[i_lookup_index] &&
                           (tag_mem[i_lookup_index] == i_lookup_tag);
    assign o_lookup_line = line_mem[i_lookup_index];   // Qualified by hit

endmodule

// ==== source/icache_bus_pkg.sv ====
package icache_bus_pkg;

    // ------------------------------------------------------------------------
    // Memory side
    // ------------------------------------------------------------------------

    // One word request, valid only with a credit in hand
    typedef struct packed {
        logic                            valid;
        icache_geometry_pkg::word_addr_t addr;     // Word address
    } mem_req_t;

    // Answers return in request order
    typedef struct packed {
        logic                       valid;
        icache_geometry_pkg::inst_t data;
    } mem_rsp_t;

    // ------------------------------------------------------------------------
    // Register port
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic        write;    // Write strobe
        logic [1:0]  addr;     // Register select
        logic [15:0] wdata;
    } csr_req_t;

    // Register map
    typedef enum logic [1:0] {
        CTRL       = 2'd0,     // Bit 0 starts invalidate-all
        HIT_COUNT  = 2'd1,
        MISS_COUNT = 2'd2
    } csr_addr_e;

    // ------------------------------------------------------------------------
    // Controller FSM
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        IDLE,      // Lookup, hits served here
        REFILL,    // Word requests and responses
        WRITE,     // Line store update
        CLEAR      // Drop every valid bit
    } ctrl_state_e;

endpackage

// ==== source/icache_geometry_pkg.sv ====
package icache_geometry_pkg;

    // ------------------------------------------------------------------------
    // Cache geometry
    // ------------------------------------------------------------------------

    localparam int LINE_WORDS  = 4;     // Words per line
    localparam int LINES       = 16;    // Direct mapped, one way
    localparam int MEM_CREDITS = 2;     // Memory request slots

    localparam int INST_WIDTH      = 32;
    localparam int WORD_ADDR_WIDTH = 30;    // Byte address minus two low bits
    localparam int OFFSET_WIDTH    = $clog2(LINE_WORDS);
    localparam int INDEX_WIDTH     = $clog2(LINES);
    localparam int TAG_WIDTH       = WORD_ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int CREDIT_WIDTH    = $clog2(MEM_CREDITS + 1);  // Holds 0..MEM_CREDITS
    localparam int COUNT_WIDTH     = 16;

    // ------------------------------------------------------------------------
    // Address and data types
    // ------------------------------------------------------------------------

    typedef logic [31:0]                 inst_addr_t;   // Byte address
    typedef logic [INST_WIDTH-1:0]       inst_t;
    typedef logic [WORD_ADDR_WIDTH-1:0]  word_addr_t;   // Memory side address

    typedef logic [TAG_WIDTH-1:0]        tag_t;
    typedef logic [INDEX_WIDTH-1:0]      index_t;
    typedef logic [OFFSET_WIDTH-1:0]     offset_t;      // Word within line

    // Word 0 sits in the low bits
    typedef logic [LINE_WORDS*INST_WIDTH-1:0] line_t;

    typedef logic [CREDIT_WIDTH-1:0]     credit_t;
    typedef logic [COUNT_WIDTH-1:0]      count_t;       // Event counter

endpackage
